// ==== rtl/procPkg.sv ====
// processor package
// widths, instruction field positions and encodings shared by the
// five-stage pipeline
package procPkg;

    localparam int xlen = 32;
    localparam int regAddrW = 5;

    typedef logic [xlen-1:0] wordT;
    typedef logic [regAddrW-1:0] regAddrT;

    // instruction field positions
    localparam int opcodeHi = 31;
    localparam int opcodeLo = 27;
    localparam int rdHi = 26;
    localparam int rdLo = 22;
    localparam int rsHi = 21;
    localparam int rsLo = 17;
    localparam int rtHi = 16;
    localparam int rtLo = 12;
    localparam int shamtHi = 11;
    localparam int shamtLo = 7;
    localparam int aluOpHi = 6;
    localparam int aluOpLo = 2;
    // immediate and jump target overlap the register fields
    localparam int immHi = 16;
    localparam int immLo = 0;
    localparam int targetHi = 26;
    localparam int targetLo = 0;

    // jal links into r31
    localparam regAddrT linkReg = 5'd31;

    // execute operand source, chosen by the hazard unit
    localparam logic [1:0] fwdReg = 2'd0;
    localparam logic [1:0] fwdMem = 2'd1;
    localparam logic [1:0] fwdWb = 2'd2;

    typedef enum logic [4:0] {
        opAlu = 5'd0,
        opJ = 5'd1,
        opBne = 5'd2,
        opJal = 5'd3,
        opJr = 5'd4,
        opAddi = 5'd5,
        opBlt = 5'd6,
        opSw = 5'd7,
        opLw = 5'd8
    } opcodeT;

    typedef enum logic [4:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOpT;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbLink
    } wbSelT;

endpackage

// ==== rtl/fetchStage.sv ====
`timescale 1ns/100ps
// fetch stage
// program counter with redirect and stall, and the fetch/decode register
module fetchStage #(
    parameter procPkg::wordT resetVector = '0
) (
    input  logic          clock,
    input  logic          arstN,
    input  logic          stall,
    input  logic          redirect,
    input  procPkg::wordT redirectPc,
    output procPkg::wordT addressImem,
    input  procPkg::wordT qImem,
    output procPkg::wordT fdInstr,
    output procPkg::wordT fdPc,
    output logic          fdFlush
);

    procPkg::wordT pc;
    procPkg::wordT pcPlus1;

    assign pcPlus1 = pc + 1'b1;
    assign addressImem = pc;

    // a redirect from execute wins over a load-use stall
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= resetVector;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pcPlus1;
        end
    end

    // squashed fetch becomes the all-zero word, flagged for decode
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            fdInstr <= '0;
            fdFlush <= 1'b1;
        end else if (redirect) begin
            fdInstr <= '0;
            fdFlush <= 1'b1;
        end else if (!stall) begin
            fdInstr <= qImem;
            fdFlush <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fdPc <= pc;
        end
    end

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/100ps
// decode stage
// field split, control decode, register-file read selection and the
// decode/execute register, which takes a bubble on stall or redirect
module decodeStage (
    input  logic                                          clock,
    input  logic                                          arstN,
    input  procPkg::wordT                                 fdInstr,
    input  procPkg::wordT                                 fdPc,
    input  logic                                          fdFlush,
    input  logic                                          stall,
    input  logic                                          redirect,
    output procPkg::regAddrT                              ctrlReadRegA,
    output procPkg::regAddrT                              ctrlReadRegB,
    input  procPkg::wordT                                 dataReadRegA,
    input  procPkg::wordT                                 dataReadRegB,
    output procPkg::wordT                                 dxA,
    output procPkg::wordT                                 dxB,
    output procPkg::wordT                                 dxImm,
    output procPkg::wordT                                 dxTarget,
    output procPkg::wordT                                 dxPc,
    output procPkg::opcodeT                               dxOp,
    output procPkg::aluOpT                                dxAluOp,
    output logic [procPkg::shamtHi-procPkg::shamtLo:0]    dxShamt,
    output procPkg::regAddrT                              dxSrcA,
    output procPkg::regAddrT                              dxSrcB,
    output procPkg::regAddrT                              dxDest,
    output logic                                          dxWrite,
    output procPkg::wbSelT                                dxWbSel
);

    procPkg::opcodeT op;
    procPkg::aluOpT aluOp;
    procPkg::wbSelT wbSel;
    procPkg::regAddrT rd;
    procPkg::regAddrT rs;
    procPkg::regAddrT rt;
    procPkg::regAddrT dest;
    procPkg::wordT imm;
    procPkg::wordT target;
    logic usesA;
    logic usesB;
    logic writes;
    logic destLive;
    logic isBranch;
    logic bubble;

    assign op = procPkg::opcodeT'(fdInstr[procPkg::opcodeHi:procPkg::opcodeLo]);
    assign rd = fdInstr[procPkg::rdHi:procPkg::rdLo];
    assign rs = fdInstr[procPkg::rsHi:procPkg::rsLo];
    assign rt = fdInstr[procPkg::rtHi:procPkg::rtLo];
    // 17-bit immediate sign-extended, 27-bit target zero-padded
    assign imm = {{(procPkg::xlen-procPkg::immHi-1){fdInstr[procPkg::immHi]}},
                  fdInstr[procPkg::immHi:procPkg::immLo]};
    assign target = {{(procPkg::xlen-procPkg::targetHi-1){1'b0}},
                     fdInstr[procPkg::targetHi:procPkg::targetLo]};

    always_comb begin
        usesA = 1'b0;
        usesB = 1'b0;
        writes = 1'b0;
        wbSel = procPkg::wbAlu;
        aluOp = procPkg::aluAdd;
        case (op)
            procPkg::opAlu: begin
                usesA = 1'b1;
                usesB = 1'b1;
                writes = 1'b1;
                aluOp = procPkg::aluOpT'(fdInstr[procPkg::aluOpHi:procPkg::aluOpLo]);
            end
            procPkg::opAddi: begin
                usesA = 1'b1;
                writes = 1'b1;
            end
            procPkg::opLw: begin
                usesA = 1'b1;
                writes = 1'b1;
                wbSel = procPkg::wbMem;
            end
            // store data and branch operands travel on port B
            procPkg::opSw, procPkg::opBne, procPkg::opBlt: begin
                usesA = 1'b1;
                usesB = 1'b1;
            end
            procPkg::opJr: usesB = 1'b1;
            procPkg::opJal: begin
                writes = 1'b1;
                wbSel = procPkg::wbLink;
            end
            default: ;
        endcase
    end

    // branches compare rd with rs, sw and jr read rd on port B
    assign isBranch = (op == procPkg::opBne) || (op == procPkg::opBlt);
    assign ctrlReadRegA = !usesA ? '0 : (isBranch ? rd : rs);
    assign ctrlReadRegB = !usesB ? '0 :
                          isBranch ? rs :
                          ((op == procPkg::opSw) || (op == procPkg::opJr)) ? rd : rt;

    // r0 is never written, so its write flag drops here
    assign dest = (op == procPkg::opJal) ? procPkg::linkReg : rd;
    assign destLive = writes && (dest != '0);
    assign bubble = stall || fdFlush || redirect;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            dxOp <= procPkg::opAlu;
            dxAluOp <= procPkg::aluAdd;
            dxSrcA <= '0;
            dxSrcB <= '0;
            dxDest <= '0;
            dxWrite <= 1'b0;
            dxWbSel <= procPkg::wbAlu;
        end else begin
            // a bubble is an ALU op with no destination
            dxOp <= bubble ? procPkg::opAlu : op;
            dxAluOp <= bubble ? procPkg::aluAdd : aluOp;
            dxSrcA <= bubble ? '0 : ctrlReadRegA;
            dxSrcB <= bubble ? '0 : ctrlReadRegB;
            dxDest <= (bubble || !destLive) ? '0 : dest;
            dxWrite <= !bubble && destLive;
            dxWbSel <= bubble ? procPkg::wbAlu : wbSel;
        end
    end

    always_ff @(posedge clock) begin
        dxA <= dataReadRegA;
        dxB <= dataReadRegB;
        dxImm <= imm;
        dxTarget <= target;
        dxPc <= fdPc;
        dxShamt <= fdInstr[procPkg::shamtHi:procPkg::shamtLo];
    end

endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/100ps
// hazard unit
// forwarding selects for the execute operands and the load-use stall
module hazardUnit (
    input  procPkg::regAddrT dxSrcA,
    input  procPkg::regAddrT dxSrcB,
    input  procPkg::regAddrT dReadA,
    input  procPkg::regAddrT dReadB,
    input  procPkg::regAddrT xmDest,
    input  logic             xmWrite,
    input  logic             xmLoad,
    input  procPkg::regAddrT dxDest,
    input  logic             dxLoad,
    input  procPkg::regAddrT mwDest,
    input  logic             mwWrite,
    output logic [1:0]       fwdA,
    output logic [1:0]       fwdB,
    output logic             stall
);

    logic memWrites;

    // memory stage beats writeback, r0 never forwards
    function automatic logic [1:0] pickSource(
        input procPkg::regAddrT src,
        input procPkg::regAddrT memDest,
        input logic             memLive,
        input procPkg::regAddrT wbDest,
        input logic             wbLive
    );
        logic [1:0] sel;
        sel = procPkg::fwdReg;
        if (src != '0 && memLive && src == memDest) begin
            sel = procPkg::fwdMem;
        end else if (src != '0 && wbLive && src == wbDest) begin
            sel = procPkg::fwdWb;
        end
        return sel;
    endfunction

    // loads carry their own write flag through memory
    assign memWrites = xmWrite || xmLoad;

    assign fwdA = pickSource(dxSrcA, xmDest, memWrites, mwDest, mwWrite);
    assign fwdB = pickSource(dxSrcB, xmDest, memWrites, mwDest, mwWrite);

    // load in execute feeding decode, loaded word not ready until memory
    assign stall = dxLoad && (dxDest != '0) &&
                   ((dReadA == dxDest) || (dReadB == dxDest));

endmodule

// ==== rtl/executeStage.sv ====
`timescale 1ns/100ps
// execute stage
// operand forwarding, ALU, branch and jump resolution, and the
// execute/memory register
module executeStage (
    input  logic                                          clock,
    input  logic                                          arstN,
    input  procPkg::wordT                                 dxA,
    input  procPkg::wordT                                 dxB,
    input  procPkg::wordT                                 dxImm,
    input  procPkg::wordT                                 dxTarget,
    input  procPkg::wordT                                 dxPc,
    input  procPkg::opcodeT                               dxOp,
    input  procPkg::aluOpT                                dxAluOp,
    input  logic [procPkg::shamtHi-procPkg::shamtLo:0]    dxShamt,
    input  procPkg::regAddrT                              dxDest,
    input  logic                                          dxWrite,
    input  procPkg::wbSelT                                dxWbSel,
    input  logic [1:0]                                    fwdA,
    input  logic [1:0]                                    fwdB,
    input  procPkg::wordT                                 mResult,
    input  procPkg::wordT                                 wValue,
    output logic                                          redirect,
    output procPkg::wordT                                 redirectPc,
    output procPkg::wordT                                 xmResult,
    output procPkg::wordT                                 xmStoreData,
    output procPkg::regAddrT                              xmDest,
    output logic                                          xmWrite,
    output logic                                          xmLoad,
    output logic                                          xmStore,
    output procPkg::wbSelT                                xmWbSel,
    output procPkg::wordT                                 xmLink
);

    procPkg::wordT opA;
    procPkg::wordT opB;
    procPkg::wordT aluB;
    procPkg::wordT aluOut;
    procPkg::wordT pcPlus1;
    procPkg::wordT branchPc;
    logic useImm;
    logic isLoad;

    function automatic procPkg::wordT pickOperand(
        input logic [1:0]    sel,
        input procPkg::wordT regVal,
        input procPkg::wordT memVal,
        input procPkg::wordT wbVal
    );
        case (sel)
            procPkg::fwdMem: return memVal;
            procPkg::fwdWb: return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA = pickOperand(fwdA, dxA, mResult, wValue);
    // port B is also the store data and the jr target
    assign opB = pickOperand(fwdB, dxB, mResult, wValue);

    // addi, lw and sw add the immediate
    assign useImm = dxOp inside {procPkg::opAddi, procPkg::opLw, procPkg::opSw};
    assign aluB = useImm ? dxImm : opB;

    always_comb begin
        case (dxAluOp)
            procPkg::aluAdd: aluOut = opA + aluB;
            procPkg::aluSub: aluOut = opA - aluB;
            procPkg::aluAnd: aluOut = opA & aluB;
            procPkg::aluOr: aluOut = opA | aluB;
            procPkg::aluSll: aluOut = opA << dxShamt;
            procPkg::aluSra: aluOut = $signed(opA) >>> dxShamt;
            default: aluOut = '0;
        endcase
    end

    // branches are relative to PC+1
    assign pcPlus1 = dxPc + 1'b1;
    assign branchPc = pcPlus1 + dxImm;

    // operand A holds rd and B holds rs for branches
    always_comb begin
        redirect = 1'b0;
        redirectPc = branchPc;
        case (dxOp)
            procPkg::opBne: redirect = (opA != opB);
            procPkg::opBlt: redirect = ($signed(opA) < $signed(opB));
            procPkg::opJ, procPkg::opJal: begin
                redirect = 1'b1;
                redirectPc = dxTarget;
            end
            procPkg::opJr: begin
                redirect = 1'b1;
                redirectPc = opB;
            end
            default: ;
        endcase
    end

    assign isLoad = (dxOp == procPkg::opLw);

    // a load writes back through xmLoad, everything else through xmWrite
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            xmDest <= '0;
            xmWrite <= 1'b0;
            xmLoad <= 1'b0;
            xmStore <= 1'b0;
            xmWbSel <= procPkg::wbAlu;
        end else begin
            xmDest <= dxDest;
            xmWrite <= dxWrite && !isLoad;
            xmLoad <= dxWrite && isLoad;
            xmStore <= (dxOp == procPkg::opSw);
            xmWbSel <= dxWbSel;
        end
    end

    always_ff @(posedge clock) begin
        xmResult <= aluOut;
        xmStoreData <= opB;
        xmLink <= pcPlus1;
    end

endmodule

// ==== rtl/memWriteback.sv ====
`timescale 1ns/100ps
// memory and writeback stages
// data memory drive, writeback value select and the memory/writeback
// register that feeds the external register file
module memWriteback (
    input  logic             clock,
    input  logic             arstN,
    input  procPkg::wordT    xmResult,
    input  procPkg::wordT    xmStoreData,
    input  procPkg::regAddrT xmDest,
    input  logic             xmWrite,
    input  logic             xmLoad,
    input  logic             xmStore,
    input  procPkg::wbSelT   xmWbSel,
    input  procPkg::wordT    xmLink,
    output procPkg::wordT    addressDmem,
    output procPkg::wordT    data,
    output logic             wren,
    input  procPkg::wordT    qDmem,
    output procPkg::wordT    mResult,
    output logic             ctrlWriteEnable,
    output procPkg::regAddrT ctrlWriteReg,
    output procPkg::wordT    dataWriteReg,
    output procPkg::wordT    wValue
);

    // ALU sum is the word address for lw and sw
    assign addressDmem = xmResult;
    assign data = xmStoreData;
    assign wren = xmStore;

    // memory answers in the same cycle, so a load forwards from here too
    always_comb begin
        case (xmWbSel)
            procPkg::wbMem: mResult = qDmem;
            procPkg::wbLink: mResult = xmLink;
            default: mResult = xmResult;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            ctrlWriteEnable <= 1'b0;
            ctrlWriteReg <= '0;
        end else begin
            ctrlWriteEnable <= xmWrite || xmLoad;
            ctrlWriteReg <= xmDest;
        end
    end

    always_ff @(posedge clock) begin
        dataWriteReg <= mResult;
    end

    // register file writes on the falling edge, execute still needs it
    assign wValue = dataWriteReg;

endmodule

// ==== rtl/processor.sv ====
`timescale 1ns/100ps
// five-stage pipelined processor
// register file and both memories sit outside and are reached
// through the ports below
module processor #(
    parameter procPkg::wordT resetVector = '0
) (
    input  logic             clock,
    input  logic             arstN,
    output procPkg::wordT    addressImem,
    input  procPkg::wordT    qImem,
    output procPkg::wordT    addressDmem,
    output procPkg::wordT    data,
    output logic             wren,
    input  procPkg::wordT    qDmem,
    output logic             ctrlWriteEnable,
    output procPkg::regAddrT ctrlWriteReg,
    output procPkg::regAddrT ctrlReadRegA,
    output procPkg::regAddrT ctrlReadRegB,
    output procPkg::wordT    dataWriteReg,
    input  procPkg::wordT    dataReadRegA,
    input  procPkg::wordT    dataReadRegB
);

    // hazard and redirect
    logic stall;
    logic redirect;
    procPkg::wordT redirectPc;
    logic [1:0] fwdA;
    logic [1:0] fwdB;

    // fetch/decode
    procPkg::wordT fdInstr;
    procPkg::wordT fdPc;
    logic fdFlush;

    // decode/execute
    procPkg::wordT dxA;
    procPkg::wordT dxB;
    procPkg::wordT dxImm;
    procPkg::wordT dxTarget;
    procPkg::wordT dxPc;
    procPkg::opcodeT dxOp;
    procPkg::aluOpT dxAluOp;
    logic [procPkg::shamtHi-procPkg::shamtLo:0] dxShamt;
    procPkg::regAddrT dxSrcA;
    procPkg::regAddrT dxSrcB;
    procPkg::regAddrT dxDest;
    logic dxWrite;
    logic dxLoad;
    procPkg::wbSelT dxWbSel;

    // execute/memory
    procPkg::wordT xmResult;
    procPkg::wordT xmStoreData;
    procPkg::regAddrT xmDest;
    logic xmWrite;
    logic xmLoad;
    logic xmStore;
    procPkg::wbSelT xmWbSel;
    procPkg::wordT xmLink;

    // forwarding values
    procPkg::wordT mResult;
    procPkg::wordT wValue;

    assign dxLoad = (dxOp == procPkg::opLw);

    fetchStage #(.resetVector(resetVector)) fetch (
        .clock, .arstN, .stall, .redirect, .redirectPc,
        .addressImem, .qImem, .fdInstr, .fdPc, .fdFlush
    );

    decodeStage decode (
        .clock, .arstN, .fdInstr, .fdPc, .fdFlush, .stall, .redirect,
        .ctrlReadRegA, .ctrlReadRegB, .dataReadRegA, .dataReadRegB,
        .dxA, .dxB, .dxImm, .dxTarget, .dxPc, .dxOp, .dxAluOp, .dxShamt,
        .dxSrcA, .dxSrcB, .dxDest, .dxWrite, .dxWbSel
    );

    // decode read ports double as the stall compare
    hazardUnit hazard (
        .dxSrcA, .dxSrcB, .dReadA(ctrlReadRegA), .dReadB(ctrlReadRegB),
        .xmDest, .xmWrite, .xmLoad, .dxDest, .dxLoad,
        .mwDest(ctrlWriteReg), .mwWrite(ctrlWriteEnable), .fwdA, .fwdB, .stall
    );

    executeStage execute (
        .clock, .arstN, .dxA, .dxB, .dxImm, .dxTarget, .dxPc, .dxOp, .dxAluOp,
        .dxShamt, .dxDest, .dxWrite, .dxWbSel, .fwdA, .fwdB, .mResult, .wValue,
        .redirect, .redirectPc, .xmResult, .xmStoreData, .xmDest, .xmWrite,
        .xmLoad, .xmStore, .xmWbSel, .xmLink
    );

    memWriteback memWb (
        .clock, .arstN, .xmResult, .xmStoreData, .xmDest, .xmWrite, .xmLoad,
        .xmStore, .xmWbSel, .xmLink, .addressDmem, .data, .wren, .qDmem,
        .mResult, .ctrlWriteEnable, .ctrlWriteReg, .dataWriteReg, .wValue
    );

endmodule

// ==== tb/processor_assert.sv ====
`timescale 1ns/100ps
// port checks bound into the processor
// quiet strobes in reset, no r0 write, first fetch at the reset vector
module processorAssert #(
    parameter procPkg::wordT resetVector = '0
) (
    input logic             clock,
    input logic             arstN,
    input logic             wren,
    input logic             ctrlWriteEnable,
    input procPkg::regAddrT ctrlWriteReg,
    input procPkg::wordT    addressImem
);

    // sampled mid-cycle so the asynchronous reset has settled
    quietInReset: assert property (@(negedge clock) !arstN |-> (!wren && !ctrlWriteEnable))
        else $error("write strobe active while reset is held");

    // writes to r0 are dropped in decode
    noWriteToR0: assert property (@(posedge clock) disable iff (!arstN)
        ctrlWriteEnable |-> (ctrlWriteReg != '0))
        else $error("register write aimed at r0");

    startAtVector: assert property (@(posedge clock)
        $rose(arstN) |-> (addressImem == resetVector))
        else $error("first fetch after reset is not at the reset vector");

endmodule

// ==== tb/processorTb.sv ====
`timescale 1ns/100ps
// testbench for the five-stage processor
// models the register file and both memories, runs a program table
// and checks every register write in program order
module processorTb;

    localparam int clkPeriod = 100;
    localparam int progLen = 37;
    localparam int dmemDepth = 64;

    logic clock;
    logic arstN;
    procPkg::wordT addressImem;
    procPkg::wordT qImem;
    procPkg::wordT addressDmem;
    procPkg::wordT data;
    logic wren;
    procPkg::wordT qDmem;
    logic ctrlWriteEnable;
    procPkg::regAddrT ctrlWriteReg;
    procPkg::regAddrT ctrlReadRegA;
    procPkg::regAddrT ctrlReadRegB;
    procPkg::wordT dataWriteReg;
    procPkg::wordT dataReadRegA;
    procPkg::wordT dataReadRegB;

    // program table, one row per instruction word with its expected write
    // and the clock edge after reset at which that write shows up
    procPkg::wordT progInstr [0:progLen-1];
    logic progWrites [0:progLen-1];
    procPkg::regAddrT progReg [0:progLen-1];
    procPkg::wordT progVal [0:progLen-1];
    int progCycle [0:progLen-1];
    int rowCount;

    procPkg::wordT imem [0:progLen-1];
    procPkg::wordT dmem [0:dmemDepth-1];
    // expected data memory, preload plus the words written by sw
    procPkg::wordT dmemExp [0:dmemDepth-1];
    procPkg::wordT regs [0:31];

    procPkg::regAddrT expReg [$];
    procPkg::wordT expVal [$];
    int expCycle [$];
    int expCount;
    int writesSeen;
    int edgesSinceReset;

    processor dut (
        .clock, .arstN, .addressImem, .qImem, .addressDmem, .data, .wren, .qDmem,
        .ctrlWriteEnable, .ctrlWriteReg, .ctrlReadRegA, .ctrlReadRegB,
        .dataWriteReg, .dataReadRegA, .dataReadRegB
    );

    bind processor processorAssert #(.resetVector(resetVector)) portChecks (
        .clock(clock), .arstN(arstN), .wren(wren), .ctrlWriteEnable(ctrlWriteEnable),
        .ctrlWriteReg(ctrlWriteReg), .addressImem(addressImem)
    );

    initial clock = 1'b0;
    always #(clkPeriod / 2) clock = ~clock;

    // past the table the instruction memory reads as the all-zero nop
    assign qImem = (addressImem < progLen) ? imem[addressImem[5:0]] : '0;
    assign qDmem = dmem[addressDmem[5:0]];
    // r0 always reads as zero
    assign dataReadRegA = (ctrlReadRegA == '0) ? '0 : regs[ctrlReadRegA];
    assign dataReadRegB = (ctrlReadRegB == '0) ? '0 : regs[ctrlReadRegB];

    // register file and data memory take writes on the falling edge
    always @(negedge clock) begin
        if (ctrlWriteEnable && ctrlWriteReg != '0) begin
            regs[ctrlWriteReg] = dataWriteReg;
        end
        if (wren) begin
            dmem[addressDmem[5:0]] = data;
        end
    end

    always @(posedge clock) begin
        if (arstN) begin
            edgesSinceReset = edgesSinceReset + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic procPkg::wordT encAlu(input procPkg::aluOpT fn, input int rd,
                                             input int rs, input int rt, input int shamt);
        procPkg::wordT w;
        w = '0;
        w[procPkg::opcodeHi:procPkg::opcodeLo] = procPkg::opAlu;
        w[procPkg::rdHi:procPkg::rdLo] = rd[4:0];
        w[procPkg::rsHi:procPkg::rsLo] = rs[4:0];
        w[procPkg::rtHi:procPkg::rtLo] = rt[4:0];
        w[procPkg::shamtHi:procPkg::shamtLo] = shamt[4:0];
        w[procPkg::aluOpHi:procPkg::aluOpLo] = fn;
        return w;
    endfunction

    // addi, lw, sw, bne, blt and jr share this layout
    function automatic procPkg::wordT encImm(input procPkg::opcodeT op, input int rd,
                                             input int rs, input int imm);
        procPkg::wordT w;
        w = '0;
        w[procPkg::opcodeHi:procPkg::opcodeLo] = op;
        w[procPkg::rdHi:procPkg::rdLo] = rd[4:0];
        w[procPkg::rsHi:procPkg::rsLo] = rs[4:0];
        w[procPkg::immHi:procPkg::immLo] = imm[16:0];
        return w;
    endfunction

    function automatic procPkg::wordT encJump(input procPkg::opcodeT op, input int target);
        procPkg::wordT w;
        w = '0;
        w[procPkg::opcodeHi:procPkg::opcodeLo] = op;
        w[procPkg::targetHi:procPkg::targetLo] = target[26:0];
        return w;
    endfunction

    task automatic stopOnFailure(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkReg(input procPkg::regAddrT got, input procPkg::regAddrT exp,
                            input string what);
        if (got !== exp) begin
            stopOnFailure($sformatf("[ERROR] %0t ns: %s is r%0d, expected r%0d",
                                    $time, what, got, exp));
        end
    endtask

    task automatic checkWord(input procPkg::wordT got, input procPkg::wordT exp,
                             input string what);
        if (got !== exp) begin
            stopOnFailure($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic addRow(input procPkg::wordT instr, input logic writes, input int rd,
                          input procPkg::wordT value, input int cycle);
        progInstr[rowCount] = instr;
        progWrites[rowCount] = writes;
        progReg[rowCount] = rd[4:0];
        progVal[rowCount] = value;
        progCycle[rowCount] = cycle;
        rowCount++;
    endtask

    // expected values follow the instruction rules by hand
    // a write lands four edges after its fetch, a load-use stall adds one
    // and a taken redirect adds two
    task automatic buildProgram();
        rowCount = 0;
        // dependent ALU chain through memory and writeback forwarding
        addRow(encImm(procPkg::opAddi, 1, 0, 5), 1'b1, 1, 32'd5, 4);
        addRow(encImm(procPkg::opAddi, 2, 1, 7), 1'b1, 2, 32'd12, 5);
        addRow(encAlu(procPkg::aluAdd, 3, 1, 2, 0), 1'b1, 3, 32'd17, 6);
        addRow(encAlu(procPkg::aluSub, 4, 3, 1, 0), 1'b1, 4, 32'd12, 7);
        addRow(encAlu(procPkg::aluOr, 5, 3, 4, 0), 1'b1, 5, 32'd29, 8);
        addRow(encAlu(procPkg::aluAnd, 6, 5, 3, 0), 1'b1, 6, 32'd17, 9);
        addRow(encAlu(procPkg::aluSll, 7, 5, 0, 3), 1'b1, 7, 32'd232, 10);
        addRow(encImm(procPkg::opAddi, 8, 0, -64), 1'b1, 8, 32'hffff_ffc0, 11);
        addRow(encAlu(procPkg::aluSra, 9, 8, 0, 2), 1'b1, 9, 32'hffff_fff0, 12);
        // stores and loads, row 12 needs the load-use stall
        addRow(encImm(procPkg::opSw, 7, 1, 3), 1'b0, 0, '0, 0);
        dmemExp[8] = 32'd232;
        addRow(encImm(procPkg::opLw, 10, 0, 8), 1'b1, 10, 32'd232, 14);
        addRow(encImm(procPkg::opLw, 11, 0, 20), 1'b1, 11, dmemExp[20], 15);
        addRow(encAlu(procPkg::aluAdd, 12, 11, 1, 0), 1'b1, 12, dmemExp[20] + 32'd5, 17);
        addRow(encImm(procPkg::opSw, 9, 2, 0), 1'b0, 0, '0, 0);
        dmemExp[12] = 32'hffff_fff0;
        // bne taken to 17, then bne not taken
        addRow(encImm(procPkg::opBne, 1, 2, 2), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opAddi, 13, 0, 99), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opAddi, 14, 0, 98), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opBne, 4, 2, 2), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opAddi, 13, 0, 1), 1'b1, 13, 32'd1, 23);
        addRow(encImm(procPkg::opAddi, 14, 0, 2), 1'b1, 14, 32'd2, 24);
        // blt taken to 23 on a negative rd, then blt not taken
        addRow(encImm(procPkg::opBlt, 9, 1, 2), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opAddi, 15, 0, 77), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opAddi, 16, 0, 78), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opBlt, 13, 9, 1), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opAddi, 15, 14, 1), 1'b1, 15, 32'd3, 29);
        // jal to 30, jr back to 26, j over 28 and 29 to 32
        addRow(encJump(procPkg::opJal, 30), 1'b1, 31, 32'd26, 30);
        addRow(encImm(procPkg::opAddi, 17, 31, 4), 1'b1, 17, 32'd30, 36);
        addRow(encJump(procPkg::opJ, 32), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opAddi, 18, 0, 55), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opAddi, 19, 0, 56), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opJr, 31, 0, 0), 1'b0, 0, '0, 0);
        addRow(encImm(procPkg::opAddi, 21, 0, 66), 1'b0, 0, '0, 0);
        // r0 as destination never writes, as source reads zero
        addRow(encImm(procPkg::opAddi, 0, 0, 123), 1'b0, 0, '0, 0);
        addRow(encAlu(procPkg::aluAdd, 22, 0, 1, 0), 1'b1, 22, 32'd5, 41);
        addRow(encAlu(procPkg::aluAdd, 0, 1, 2, 0), 1'b0, 0, '0, 0);
        addRow(encAlu(procPkg::aluOr, 23, 0, 0, 0), 1'b1, 23, 32'd0, 43);
        addRow(encImm(procPkg::opAddi, 24, 23, 3), 1'b1, 24, 32'd3, 44);
    endtask

    // monitor, each register write against the next expected entry
    always @(negedge clock) begin
        if (arstN && ctrlWriteEnable) begin
            if (writesSeen >= expCount) begin
                stopOnFailure("register write seen after all expected writes");
            end else if (edgesSinceReset != expCycle[writesSeen]) begin
                stopOnFailure($sformatf(
                    "[ERROR] %0t ns: write %0d came %0d edges after reset, expected %0d",
                    $time, writesSeen, edgesSinceReset, expCycle[writesSeen]));
            end else begin
                checkReg(ctrlWriteReg, expReg[writesSeen], "write register");
                checkWord(dataWriteReg, expVal[writesSeen], "write value");
                writesSeen = writesSeen + 1;
            end
        end
    end

    initial begin
        logic [31:0] state;
        arstN = 1'b0;
        writesSeen = 0;
        edgesSinceReset = 0;
        state = 32'h3a0f;
        for (int i = 0; i < dmemDepth; i++) begin
            state = xorshift32(state);
            dmem[i] = state;
            dmemExp[i] = state;
        end
        // register contents tagged by number, r0 is masked by the read mux
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'hc0de_0000 + i;
        end
        buildProgram();
        for (int i = 0; i < progLen; i++) begin
            imem[i] = progInstr[i];
            if (progWrites[i]) begin
                expReg.push_back(progReg[i]);
                expVal.push_back(progVal[i]);
                expCycle.push_back(progCycle[i]);
            end
        end
        expCount = expReg.size();
        repeat (4) @(negedge clock);
        arstN = 1'b1;
        checkWord(addressImem, 32'd0, "first fetch address");
        wait (writesSeen == expCount);
        // a stray write from a squashed slot would still reach the monitor
        repeat (8) @(negedge clock);
        for (int i = 0; i < dmemDepth; i++) begin
            checkWord(dmem[i], dmemExp[i], $sformatf("data memory word %0d", i));
        end
        if (rowCount == progLen) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stopOnFailure("program table length does not match its declared size");
        end
    end

    // watchdog, four cycles per row plus pipeline fill
    initial begin
        #((progLen * 4 + 20) * clkPeriod);
        stopOnFailure("watchdog expired before all expected writes were seen");
    end

endmodule

// ==== processor.f ====
rtl/procPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/memWriteback.sv
rtl/processor.sv
tb/processor_assert.sv
tb/processorTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f processor.f \
		--top-module processorTb -o processorTb

run: compile
	./obj_dir/processorTb 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
